// File: logic/fetch_config.svh
// reset vector, data width and epoch width macros for the fetch stage
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first instruction address after reset
`define FETCH_RESET_PC 32'h3000_0000

// address and instruction word width
`define FETCH_XLEN 32

// request epoch tag width
// two bits cover the redirects that can pass while one read is in flight
`define FETCH_EPOCH_W 2

`endif

// File: logic/rv_inst_pkg.sv
// RV32 instruction word union with raw and J-type views, JAL opcode constant
`default_nettype none

package rv_inst_pkg;

	// major opcode of jal
	localparam logic [6:0] OPC_JAL = 7'b110_1111;

	// generic field split of an instruction word
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_raw_t;

	// J-type immediate scattering
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_j_t;

	// one fetched word seen both ways
	typedef union packed {
		inst_raw_t raw;
		inst_j_t   j;
	} inst_word_u;

endpackage

`default_nettype wire

// File: logic/fetch_ctrl_pkg.sv
// fetch state machine encoding and request epoch type
`default_nettype none

`include "fetch_config.svh"

package fetch_ctrl_pkg;

	// read channel sequencing
	// data state kept at 2'b11 so idle and data differ in both bits
	typedef enum logic [1:0] {
		FETCH_IDLE = 2'b00,
		FETCH_ADDR = 2'b01,
		FETCH_DATA = 2'b11
	} fetch_state_e;

	// tag attached to each read request
	typedef logic [`FETCH_EPOCH_W-1:0] epoch_t;

endpackage

`default_nettype wire

// File: logic/fetch_unit.sv
// fetch unit with read request FSM, epoch tracking, instruction hold register and valid
`timescale 1ns/10ps
`default_nettype none

`include "fetch_config.svh"

module fetch_unit (
	input  wire                   clk,
	input  wire                   reset,
	output logic                  mem_arvalid,
	input  wire                   mem_arready,
	input  wire                   mem_rvalid,
	output logic                  mem_rready,
	input  wire [`FETCH_XLEN-1:0] mem_rdata,
	input  wire                   decode_ready,
	input  wire                   decode_stall,
	input  wire                   redirect_valid,
	input  wire                   exc_valid,
	output logic                  fetch_valid,
	output logic [`FETCH_XLEN-1:0] fetch_inst,
	output logic                  advance
);

	fetch_ctrl_pkg::fetch_state_e state;
	fetch_ctrl_pkg::epoch_t       cur_epoch;
	fetch_ctrl_pkg::epoch_t       req_epoch;
	logic       redirect_q;
	logic       exc_q;
	logic [1:0] redirect_edge;
	logic [1:0] exc_edge;
	logic       epoch_step;
	logic       can_accept;
	logic       resp_fire;
	logic       resp_keep;

	// previous level against current level
	assign redirect_edge = {redirect_q, redirect_valid};
	assign exc_edge      = {exc_q, exc_valid};
	assign epoch_step    = (redirect_edge == 2'b01) || (exc_edge == 2'b01);

	// decode takes the held word
	assign advance = fetch_valid && decode_ready;

	// room for a new word next cycle
	assign can_accept = !fetch_valid || (advance && !decode_stall);

	assign resp_fire = mem_rvalid && mem_rready;

	// stale responses from before a redirect or trap are thrown away
	assign resp_keep = (req_epoch == cur_epoch) && !redirect_valid && !exc_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			redirect_q <= 1'b0;
			exc_q      <= 1'b0;
		end else begin
			redirect_q <= redirect_valid;
			exc_q      <= exc_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_epoch <= '0;
			req_epoch <= '0;
		end else begin
			// tag the request with the epoch live at its address transfer
			if (mem_arvalid && mem_arready) begin
				req_epoch <= cur_epoch;
			end
			if (epoch_step) begin
				cur_epoch <= cur_epoch + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= fetch_ctrl_pkg::FETCH_IDLE;
			mem_arvalid <= 1'b0;
			mem_rready  <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			// accepted word leaves, a landing word below overrides this
			if (advance) begin
				fetch_valid <= 1'b0;
			end
			case (state)
				fetch_ctrl_pkg::FETCH_IDLE: begin
					if (can_accept) begin
						mem_arvalid <= 1'b1;
						state       <= fetch_ctrl_pkg::FETCH_ADDR;
					end
				end
				fetch_ctrl_pkg::FETCH_ADDR: begin
					if (mem_arready) begin
						mem_arvalid <= 1'b0;
						mem_rready  <= 1'b1;
						state       <= fetch_ctrl_pkg::FETCH_DATA;
					end
				end
				fetch_ctrl_pkg::FETCH_DATA: begin
					if (resp_fire) begin
						mem_rready <= 1'b0;
						state      <= fetch_ctrl_pkg::FETCH_IDLE;
						if (resp_keep) begin
							fetch_valid <= 1'b1;
						end
					end
				end
				default: begin
					mem_arvalid <= 1'b0;
					mem_rready  <= 1'b0;
					state       <= fetch_ctrl_pkg::FETCH_IDLE;
				end
			endcase
		end
	end

	// hold register, only written by a kept response
	always_ff @(posedge clk) begin
		if (resp_fire && resp_keep) begin
			fetch_inst <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

// File: logic/pc_sequencer.sv
// PC register with next-PC priority select, JAL predecode target, PC+4 and misalign flag
`timescale 1ns/10ps
`default_nettype none

`include "fetch_config.svh"

module pc_sequencer (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   advance,
	input  wire [`FETCH_XLEN-1:0] fetch_inst,
	input  wire                   redirect_valid,
	input  wire [`FETCH_XLEN-1:0] redirect_pc,
	input  wire                   exc_valid,
	input  wire [`FETCH_XLEN-1:0] trap_vector,
	output logic [`FETCH_XLEN-1:0] pc,
	output logic [`FETCH_XLEN-1:0] pc_plus4,
	output logic                  misaligned
);

	rv_inst_pkg::inst_word_u inst;
	logic                   is_jal;
	logic [`FETCH_XLEN-1:0] jal_offset;
	logic [`FETCH_XLEN-1:0] jal_target;
	logic [`FETCH_XLEN-1:0] next_pc;
	logic                   pc_load;

	assign inst = fetch_inst;

	// opcode from the raw view, offset from the J-type view
	assign is_jal = (inst.raw.opcode == rv_inst_pkg::OPC_JAL);
	assign jal_offset = {{12{inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
		inst.j.imm_10_1, 1'b0};
	assign jal_target = pc + jal_offset;

	assign pc_plus4 = pc + 32'd4;

	// trap beats redirect beats predicted jal
	always_comb begin
		if (exc_valid) begin
			next_pc = trap_vector;
		end else if (redirect_valid) begin
			next_pc = redirect_pc;
		end else if (is_jal) begin
			next_pc = jal_target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	assign pc_load = advance || redirect_valid || exc_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `FETCH_RESET_PC;
		end else if (pc_load) begin
			pc <= next_pc;
		end
	end

	// instruction address misaligned
	assign misaligned = (pc[1:0] != 2'b00);

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
// fetch stage top joining the fetch unit and the PC sequencer
`timescale 1ns/10ps
`default_nettype none

`include "fetch_config.svh"

module fetch_top (
	input  wire                   clk,
	input  wire                   reset,
	output wire [`FETCH_XLEN-1:0] mem_araddr,
	output wire                   mem_arvalid,
	input  wire                   mem_arready,
	input  wire                   mem_rvalid,
	output wire                   mem_rready,
	input  wire [`FETCH_XLEN-1:0] mem_rdata,
	input  wire                   decode_ready,
	input  wire                   decode_stall,
	input  wire                   redirect_valid,
	input  wire [`FETCH_XLEN-1:0] redirect_pc,
	input  wire                   exc_valid,
	input  wire [`FETCH_XLEN-1:0] trap_vector,
	output wire                   fetch_valid,
	output wire [`FETCH_XLEN-1:0] fetch_inst,
	output wire [`FETCH_XLEN-1:0] fetch_pc,
	output wire [`FETCH_XLEN-1:0] fetch_pc_plus4,
	output wire                   fetch_misaligned
);

	wire advance;

	fetch_unit fetch_unit_inst (
		.clk            (clk),
		.reset          (reset),
		.mem_arvalid    (mem_arvalid),
		.mem_arready    (mem_arready),
		.mem_rvalid     (mem_rvalid),
		.mem_rready     (mem_rready),
		.mem_rdata      (mem_rdata),
		.decode_ready   (decode_ready),
		.decode_stall   (decode_stall),
		.redirect_valid (redirect_valid),
		.exc_valid      (exc_valid),
		.fetch_valid    (fetch_valid),
		.fetch_inst     (fetch_inst),
		.advance        (advance)
	);

	pc_sequencer pc_sequencer_inst (
		.clk            (clk),
		.reset          (reset),
		.advance        (advance),
		.fetch_inst     (fetch_inst),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.exc_valid      (exc_valid),
		.trap_vector    (trap_vector),
		.pc             (fetch_pc),
		.pc_plus4       (fetch_pc_plus4),
		.misaligned     (fetch_misaligned)
	);

	// the read address is always the current PC
	assign mem_araddr = fetch_pc;

endmodule

`default_nettype wire

// File: sim/imem_read_model.sv
// instruction memory read model with randomly delayed address ready and read response
`timescale 1ns/10ps
`default_nettype none

module imem_read_model (
	input  wire         clk,
	input  wire         reset,
	input  wire  [31:0] araddr,
	input  wire         arvalid,
	output logic        arready,
	output logic        rvalid,
	input  wire         rready,
	output logic [31:0] rdata,
	input  wire         ar_hold,
	input  wire         r_hold
);

	logic [31:0] words [logic [31:0]];
	logic [31:0] addr_q;
	logic        pending;

	// word aligned store, called while the trace is loaded
	task automatic store_word(input logic [31:0] addr, input logic [31:0] data);
		words[{addr[31:2], 2'b00}] = data;
	endtask

	// unwritten words read back a pattern of their own address
	function automatic logic [31:0] read_word(input logic [31:0] addr);
		logic [31:0] base;
		base = {addr[31:2], 2'b00};
		if (words.exists(base)) begin
			return words[base];
		end
		return base ^ 32'ha5c3_5a3c;
	endfunction

	assign arready = arvalid && !ar_hold;

	always @(posedge clk) begin
		if (reset) begin
			rvalid  <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (arvalid && arready) begin
				pending <= 1'b1;
				addr_q  <= araddr;
			end
			// response waits a random number of cycles, then holds until taken
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end else if (pending && !rvalid && !r_hold) begin
				rvalid  <= 1'b1;
				rdata   <= read_word(addr_q);
				pending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/fetch_tb.sv
// fetch stage testbench with trace driven memory, redirects, back-pressure and checks
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

	logic        clk;
	logic        reset;
	logic [31:0] mem_araddr;
	logic        mem_arvalid;
	logic        mem_arready;
	logic        mem_rvalid;
	logic        mem_rready;
	logic [31:0] mem_rdata;
	logic        decode_ready;
	logic        decode_stall;
	logic        redirect_valid;
	logic [31:0] redirect_pc;
	logic        exc_valid;
	logic [31:0] trap_vector;
	logic        fetch_valid;
	logic [31:0] fetch_inst;
	logic [31:0] fetch_pc;
	logic [31:0] fetch_pc_plus4;
	logic        fetch_misaligned;
	logic        ar_hold;
	logic        r_hold;

	logic [31:0] lfsr;
	byte         ev_kind [$];
	int          ev_count [$];
	logic [31:0] ev_target [$];
	logic        ev_mis [$];
	logic [31:0] exp_pc [$];
	logic [31:0] exp_inst [$];
	int          ev_idx;
	int          exp_idx;
	int          errors;
	int          cycles;
	int          limit;
	int          mis_check_cycle;
	logic        mis_expect;
	logic        pulse_on;
	logic        held_seen;
	logic [31:0] held_pc;
	logic [31:0] held_inst;
	logic        run_over;

	fetch_top fetch_top_inst (
		.clk              (clk),
		.reset            (reset),
		.mem_araddr       (mem_araddr),
		.mem_arvalid      (mem_arvalid),
		.mem_arready      (mem_arready),
		.mem_rvalid       (mem_rvalid),
		.mem_rready       (mem_rready),
		.mem_rdata        (mem_rdata),
		.decode_ready     (decode_ready),
		.decode_stall     (decode_stall),
		.redirect_valid   (redirect_valid),
		.redirect_pc      (redirect_pc),
		.exc_valid        (exc_valid),
		.trap_vector      (trap_vector),
		.fetch_valid      (fetch_valid),
		.fetch_inst       (fetch_inst),
		.fetch_pc         (fetch_pc),
		.fetch_pc_plus4   (fetch_pc_plus4),
		.fetch_misaligned (fetch_misaligned)
	);

	imem_read_model imem (
		.clk     (clk),
		.reset   (reset),
		.araddr  (mem_araddr),
		.arvalid (mem_arvalid),
		.arready (mem_arready),
		.rvalid  (mem_rvalid),
		.rready  (mem_rready),
		.rdata   (mem_rdata),
		.ar_hold (ar_hold),
		.r_hold  (r_hold)
	);

	// galois form, right shifting
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_step(lfsr);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic load_trace();
		int          fd;
		int          c;
		int          n;
		int          want_n;
		int          cnt;
		int          mis;
		byte         ch;
		logic [31:0] a;
		logic [31:0] d;
		fd = $fopen("sim/fetch_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file sim/fetch_trace.txt");
			errors++;
			return;
		end
		c = $fgetc(fd);
		while (c != -1) begin
			ch = c[7:0];
			n = 0;
			want_n = 0;
			if (ch == "#") begin
				while (c != -1 && c[7:0] != "\n") begin
					c = $fgetc(fd);
				end
			end else if (ch == "M") begin
				n = $fscanf(fd, " %h %h", a, d);
				want_n = 2;
				imem.store_word(a, d);
			end else if (ch == "R" || ch == "X") begin
				n = $fscanf(fd, " %d %h %d", cnt, a, mis);
				want_n = 3;
				ev_kind.push_back(ch);
				ev_count.push_back(cnt);
				ev_target.push_back(a);
				ev_mis.push_back(mis != 0);
			end else if (ch == "E") begin
				n = $fscanf(fd, " %h %h", a, d);
				want_n = 2;
				exp_pc.push_back(a);
				exp_inst.push_back(d);
			end else if (ch > " ") begin
				$display("trace has a line of unknown kind %c", ch);
				errors++;
			end
			if (n != want_n) begin
				$display("trace line of kind %c has missing fields", ch);
				errors++;
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		logic b;
		take_bit(b);
		decode_ready <= b;
		take_bit(b);
		decode_stall <= b;
		take_bit(b);
		ar_hold <= b;
		take_bit(b);
		r_hold <= b;
		if (!reset && !run_over) begin
			// state straight out of reset
			if (cycles == 0) begin
				check_value("fetch_valid", {31'b0, fetch_valid}, 32'd0);
				check_value("mem_arvalid", {31'b0, mem_arvalid}, 32'd0);
				check_value("mem_rready", {31'b0, mem_rready}, 32'd0);
				check_value("mem_araddr", mem_araddr, 32'h3000_0000);
			end
			cycles++;
			// held word must not move under back-pressure
			if (fetch_valid) begin
				if (!held_seen) begin
					held_pc = fetch_pc;
					held_inst = fetch_inst;
					held_seen = 1'b1;
				end
				check_value("fetch_pc", fetch_pc, held_pc);
				check_value("fetch_inst", fetch_inst, held_inst);
			end
			if (fetch_valid && decode_ready) begin
				check_value("fetch_pc", fetch_pc, exp_pc[exp_idx]);
				check_value("fetch_pc_plus4", fetch_pc_plus4, exp_pc[exp_idx] + 32'd4);
				check_value("fetch_inst", fetch_inst, exp_inst[exp_idx]);
				held_seen = 1'b0;
				exp_idx++;
				if (exp_idx == exp_pc.size()) begin
					run_over = 1'b1;
				end
			end
			// one cycle pulse, only while no word is held or landing
			if (pulse_on) begin
				redirect_valid <= 1'b0;
				exc_valid <= 1'b0;
				pulse_on = 1'b0;
			end else if (ev_idx < ev_count.size() && ev_count[ev_idx] == exp_idx
				&& !fetch_valid && !(mem_rvalid && mem_rready)) begin
				while (ev_idx < ev_count.size() && ev_count[ev_idx] == exp_idx) begin
					if (ev_kind[ev_idx] == "X") begin
						exc_valid <= 1'b1;
						trap_vector <= ev_target[ev_idx];
					end else begin
						redirect_valid <= 1'b1;
						redirect_pc <= ev_target[ev_idx];
					end
					mis_expect = ev_mis[ev_idx];
					ev_idx++;
				end
				pulse_on = 1'b1;
				mis_check_cycle = cycles + 2;
			end
			// pc has taken the new target by then
			if (cycles == mis_check_cycle) begin
				check_value("fetch_misaligned", {31'b0, fetch_misaligned}, {31'b0, mis_expect});
			end
			if (cycles >= limit && !run_over) begin
				$display("timeout after %0d cycles with %0d of %0d fetches accepted",
					cycles, exp_idx, exp_pc.size());
				errors++;
				run_over = 1'b1;
			end
		end
	end

	initial begin
		reset = 1'b1;
		decode_ready = 1'b0;
		decode_stall = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		exc_valid = 1'b0;
		trap_vector = '0;
		ar_hold = 1'b1;
		r_hold = 1'b1;
		lfsr = 32'h167f_6c18;
		ev_idx = 0;
		exp_idx = 0;
		errors = 0;
		cycles = 0;
		mis_check_cycle = -1;
		mis_expect = 1'b0;
		pulse_on = 1'b0;
		held_seen = 1'b0;
		load_trace();
		limit = exp_pc.size() * 64;
		run_over = (exp_pc.size() == 0);
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		wait (run_over);
		if (ev_idx < ev_count.size()) begin
			$display("trace ended early with %0d redirect or exception events not issued",
				ev_count.size() - ev_idx);
			errors++;
		end
		$display("checked %0d of %0d fetches, errors: %0d", exp_idx, exp_pc.size(), errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/rv_inst_pkg.sv
logic/fetch_ctrl_pkg.sv
logic/fetch_unit.sv
logic/pc_sequencer.sv
logic/fetch_top.sv
sim/imem_read_model.sv
sim/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f sources.f --top-module fetch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vfetch_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed"; then
	exit 0
fi
exit 1

// File: sim/fetch_trace.txt
# M word_addr data | R or X accept_count target expected_misaligned | E fetch_pc fetch_inst
# R and X lines with the same accept count pulse together, the trap wins
M 30000000 00000013
M 30000004 00100093
M 30000008 0100006f
M 30000018 00300193
M 3000001c 00400213
M 30000040 00500293
M 30000044 00600313
M 30000080 00c00613
M 30000200 00700393
M 30000204 00800413
M 30000300 00900493
M 30000304 00a00513
M 30000400 00b00593
M 30000404 ffdff06f
R 5 30000040 0
R 7 30000080 0
X 7 30000200 0
R 9 30000302 1
R 11 30000400 0
E 30000000 00000013
E 30000004 00100093
E 30000008 0100006f
E 30000018 00300193
E 3000001c 00400213
E 30000040 00500293
E 30000044 00600313
E 30000200 00700393
E 30000204 00800413
E 30000302 00900493
E 30000306 00a00513
E 30000400 00b00593
E 30000404 ffdff06f
E 30000400 00b00593
